// File: logic/fft_pkg.sv
package fft_pkg;

  // frame and butterfly geometry
  localparam int n_points      = 16;
  localparam int radix         = 4;
  localparam int n_butterflies = n_points / radix;

  // sample format
  localparam int data_w_default = 16;

  // twiddles are Q1.14, 16384 is 1.0
  localparam int tw_frac = 14;
  localparam int tw_w    = 16;

  // cos(2*pi*e/16) scaled by 2^14
  localparam logic signed [tw_w-1:0] tw_re_table [n_points] = '{
    16'sd16384,
    16'sd15137,
    16'sd11585,
    16'sd6270,
    16'sd0,
    -16'sd6270,
    -16'sd11585,
    -16'sd15137,
    -16'sd16384,
    -16'sd15137,
    -16'sd11585,
    -16'sd6270,
    16'sd0,
    16'sd6270,
    16'sd11585,
    16'sd15137
  };

  // -sin(2*pi*e/16) scaled by 2^14
  localparam logic signed [tw_w-1:0] tw_im_table [n_points] = '{
    16'sd0,
    -16'sd6270,
    -16'sd11585,
    -16'sd15137,
    -16'sd16384,
    -16'sd15137,
    -16'sd11585,
    -16'sd6270,
    16'sd0,
    16'sd6270,
    16'sd11585,
    16'sd15137,
    16'sd16384,
    16'sd15137,
    16'sd11585,
    16'sd6270
  };

endpackage

// File: logic/cmul.sv
module cmul #(
  parameter int data_w = fft_pkg::data_w_default
) (
  input  logic signed [data_w-1:0]        a_re,
  input  logic signed [data_w-1:0]        a_im,
  input  logic signed [fft_pkg::tw_w-1:0] w_re,
  input  logic signed [fft_pkg::tw_w-1:0] w_im,
  output logic signed [data_w-1:0]        p_re,
  output logic signed [data_w-1:0]        p_im
);
  import fft_pkg::*;

  // one extra bit for the sum of two products
  localparam int prod_w = data_w + tw_w + 1;

  logic signed [prod_w-1:0] rr;
  logic signed [prod_w-1:0] ii;
  logic signed [prod_w-1:0] ri;
  logic signed [prod_w-1:0] ir;
  logic signed [prod_w-1:0] sum_re;
  logic signed [prod_w-1:0] sum_im;
  logic signed [prod_w-1:0] sh_re;
  logic signed [prod_w-1:0] sh_im;

  // full-width partial products
  assign rr = a_re * w_re;
  assign ii = a_im * w_im;
  assign ri = a_re * w_im;
  assign ir = a_im * w_re;

  assign sum_re = rr - ii;
  assign sum_im = ri + ir;

  // drop the Q14 fraction, rounding toward minus infinity
  assign sh_re = sum_re >>> tw_frac;
  assign sh_im = sum_im >>> tw_frac;

  assign p_re = sh_re[data_w-1:0];
  assign p_im = sh_im[data_w-1:0];

endmodule

// File: logic/radix4_butterfly.sv
module radix4_butterfly #(
  parameter int data_w    = fft_pkg::data_w_default,
  parameter int stage_idx = 0,
  parameter int col       = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic signed [data_w-1:0] x_re [fft_pkg::radix],
  input  logic signed [data_w-1:0] x_im [fft_pkg::radix],
  output logic signed [data_w-1:0] y_re [fft_pkg::radix],
  output logic signed [data_w-1:0] y_im [fft_pkg::radix]
);
  import fft_pkg::*;

  // four terms need two guard bits
  localparam int sum_w = data_w + 2;

  logic signed [sum_w-1:0]  a_re [radix];
  logic signed [sum_w-1:0]  a_im [radix];
  logic signed [sum_w-1:0]  s_re [radix];
  logic signed [sum_w-1:0]  s_im [radix];
  logic signed [data_w-1:0] q_re [radix];
  logic signed [data_w-1:0] q_im [radix];
  logic signed [data_w-1:0] t_re [radix];
  logic signed [data_w-1:0] t_im [radix];

  always_comb begin
    for (int n = 0; n < radix; n++) begin
      a_re[n] = sum_w'(x_re[n]);
      a_im[n] = sum_w'(x_im[n]);
    end

    // k=0, all weights 1
    s_re[0] = a_re[0] + a_re[1] + a_re[2] + a_re[3];
    s_im[0] = a_im[0] + a_im[1] + a_im[2] + a_im[3];
    // k=1, weights 1, -j, -1, +j
    s_re[1] = a_re[0] + a_im[1] - a_re[2] - a_im[3];
    s_im[1] = a_im[0] - a_re[1] - a_im[2] + a_re[3];
    // k=2, weights 1, -1, 1, -1
    s_re[2] = a_re[0] - a_re[1] + a_re[2] - a_re[3];
    s_im[2] = a_im[0] - a_im[1] + a_im[2] - a_im[3];
    // k=3, weights 1, +j, -1, -j
    s_re[3] = a_re[0] - a_im[1] - a_re[2] + a_im[3];
    s_im[3] = a_im[0] + a_re[1] - a_im[2] - a_re[3];

    // quarter scaling, floor
    for (int k = 0; k < radix; k++) begin
      q_re[k] = s_re[k][sum_w-1:2];
      q_im[k] = s_im[k][sum_w-1:2];
    end
  end

  // output 0 always sees twiddle entry 0
  assign t_re[0] = q_re[0];
  assign t_im[0] = q_im[0];

  for (genvar k = 1; k < radix; k++) begin : g_out
    if (stage_idx == 0) begin : g_tw
      cmul #(
        .data_w(data_w)
      ) u_cmul (
        .a_re(q_re[k]),
        .a_im(q_im[k]),
        .w_re(tw_re_table[col*k]),
        .w_im(tw_im_table[col*k]),
        .p_re(t_re[k]),
        .p_im(t_im[k])
      );
    end else begin : g_bypass
      assign t_re[k] = q_re[k];
      assign t_im[k] = q_im[k];
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int k = 0; k < radix; k++) begin
        y_re[k] <= '0;
        y_im[k] <= '0;
      end
    end else begin
      for (int k = 0; k < radix; k++) begin
        y_re[k] <= t_re[k];
        y_im[k] <= t_im[k];
      end
    end
  end

endmodule

// File: logic/fft_stage.sv
module fft_stage #(
  parameter int data_w    = fft_pkg::data_w_default,
  parameter int stage_idx = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic signed [data_w-1:0] in_re  [fft_pkg::n_points],
  input  logic signed [data_w-1:0] in_im  [fft_pkg::n_points],
  output logic                     out_valid,
  output logic signed [data_w-1:0] out_re [fft_pkg::n_points],
  output logic signed [data_w-1:0] out_im [fft_pkg::n_points]
);
  import fft_pkg::*;

  logic signed [data_w-1:0] bf_in_re  [n_butterflies][radix];
  logic signed [data_w-1:0] bf_in_im  [n_butterflies][radix];
  logic signed [data_w-1:0] bf_out_re [n_butterflies][radix];
  logic signed [data_w-1:0] bf_out_im [n_butterflies][radix];

  for (genvar b = 0; b < n_butterflies; b++) begin : g_col
    for (genvar n = 0; n < radix; n++) begin : g_pt
      if (stage_idx == 0) begin : g_first
        // column b takes samples b, b+4, b+8, b+12
        assign bf_in_re[b][n] = in_re[b + n_butterflies*n];
        assign bf_in_im[b][n] = in_im[b + n_butterflies*n];

        // grid laid out as [butterfly][output]
        assign out_re[radix*b + n] = bf_out_re[b][n];
        assign out_im[radix*b + n] = bf_out_im[b][n];
      end else begin : g_last
        // transpose: butterfly b gets output k=b of every first-stage column
        assign bf_in_re[b][n] = in_re[radix*n + b];
        assign bf_in_im[b][n] = in_im[radix*n + b];

        // output k of butterfly b is bin b + 4k
        assign out_re[b + n_butterflies*n] = bf_out_re[b][n];
        assign out_im[b + n_butterflies*n] = bf_out_im[b][n];
      end
    end

    radix4_butterfly #(
      .data_w   (data_w),
      .stage_idx(stage_idx),
      .col      (b)
    ) u_bf (
      .clk (clk),
      .rst (rst),
      .x_re(bf_in_re[b]),
      .x_im(bf_in_im[b]),
      .y_re(bf_out_re[b]),
      .y_im(bf_out_im[b])
    );
  end

  // valid follows the butterfly output register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

endmodule

// File: logic/fft16_top.sv
module fft16_top #(
  parameter int data_w = fft_pkg::data_w_default
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic signed [data_w-1:0] in_re  [fft_pkg::n_points],
  input  logic signed [data_w-1:0] in_im  [fft_pkg::n_points],
  output logic                     out_valid,
  output logic signed [data_w-1:0] out_re [fft_pkg::n_points],
  output logic signed [data_w-1:0] out_im [fft_pkg::n_points]
);
  import fft_pkg::*;

  // first-stage grid, [butterfly j][output k] flattened as 4*j + k
  logic                     s0_valid;
  logic signed [data_w-1:0] s0_re [n_points];
  logic signed [data_w-1:0] s0_im [n_points];

  // stride-4 columns with twiddles
  fft_stage #(
    .data_w   (data_w),
    .stage_idx(0)
  ) u_stage0 (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_re    (in_re),
    .in_im    (in_im),
    .out_valid(s0_valid),
    .out_re   (s0_re),
    .out_im   (s0_im)
  );

  // transposed grid, natural bin order out
  fft_stage #(
    .data_w   (data_w),
    .stage_idx(1)
  ) u_stage1 (
    .clk      (clk),
    .rst      (rst),
    .in_valid (s0_valid),
    .in_re    (s0_re),
    .in_im    (s0_im),
    .out_valid(out_valid),
    .out_re   (out_re),
    .out_im   (out_im)
  );

endmodule

// File: tb/tb_clock.sv
module tb_clock #(
  parameter int period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

// File: tb/fft16_assert.sv
module fft16_assert #(
  parameter int data_w = fft_pkg::data_w_default
) (
  input logic                     clk,
  input logic                     rst,
  input logic                     in_valid,
  input logic                     out_valid,
  input logic signed [data_w-1:0] out_re [fft_pkg::n_points],
  input logic signed [data_w-1:0] out_im [fft_pkg::n_points]
);
  import fft_pkg::*;

  int   fail_count = 0;
  logic out_x;

  // any unknown bit in the result vector
  always_comb begin
    out_x = 1'b0;
    for (int b = 0; b < n_points; b++) begin
      if ($isunknown(out_re[b]) || $isunknown(out_im[b])) begin
        out_x = 1'b1;
      end
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk) !rst |-> !out_valid)
    else begin
      $error("out_valid high while reset is asserted");
      fail_count++;
    end

  a_in_to_out: assert property (@(posedge clk) disable iff (!rst) in_valid |-> ##2 out_valid)
    else begin
      $error("frame accepted but out_valid missing two cycles later");
      fail_count++;
    end

  a_out_from_in: assert property (@(posedge clk) disable iff (!rst)
                                   out_valid |-> $past(in_valid, 2))
    else begin
      $error("out_valid without a frame two cycles earlier");
      fail_count++;
    end

  a_known_out: assert property (@(posedge clk) disable iff (!rst) out_valid |-> !out_x)
    else begin
      $error("unknown bits on outputs while out_valid is high");
      fail_count++;
    end

endmodule

bind fft16_top fft16_assert #(
  .data_w(data_w)
) u_assert (
  .clk      (clk),
  .rst      (rst),
  .in_valid (in_valid),
  .out_valid(out_valid),
  .out_re   (out_re),
  .out_im   (out_im)
);

// File: tb/fft16_tb.sv
module fft16_tb;
  import fft_pkg::*;

  localparam int data_w     = data_w_default;
  localparam int rst_cycles = 16;
  localparam int n_random   = 20;
  localparam int n_gapped   = 12;
  localparam int max_gap    = 3;
  // impulse, dc and tone plus the two random tests
  localparam int n_frames       = 3 + n_random + n_gapped;
  // margin of 40 covers idle time and pipeline drain between tests
  localparam int timeout_cycles = rst_cycles + n_frames + n_gapped * max_gap + 40;

  typedef logic signed [data_w-1:0] sample_t;

  logic    clk;
  logic    rst;
  logic    in_valid;
  sample_t in_re  [n_points];
  sample_t in_im  [n_points];
  logic    out_valid;
  sample_t out_re [n_points];
  sample_t out_im [n_points];

  int seed;
  int cycle = 0;
  int sample_errs = 0;
  int valid_errs = 0;
  int proto_errs = 0;
  int assert_errs;

  // expected results as 16 samples per frame and the cycle each frame is due
  sample_t exp_re_q [$];
  sample_t exp_im_q [$];
  int      due_q [$];

  tb_clock #(
    .period(4)
  ) u_clock (
    .clk(clk)
  );

  fft16_top #(
    .data_w(data_w)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_re    (in_re),
    .in_im    (in_im),
    .out_valid(out_valid),
    .out_re   (out_re),
    .out_im   (out_im)
  );

  task automatic check_sample(input string name, input int bin, input sample_t exp,
                              input sample_t act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s[%0d] expected %0d got %0d", $time, name, bin, exp, act);
      sample_errs++;
    end
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t out_valid expected %b got %b", $time, exp, act);
      valid_errs++;
    end
  endtask

  // four-point DFT with weights (-j)^(n*k) then a floor divide by 4
  task automatic dft4(input sample_t a_re [radix], input sample_t a_im [radix],
                      output sample_t y_re [radix], output sample_t y_im [radix]);
    int acc_re;
    int acc_im;
    for (int k = 0; k < radix; k++) begin
      acc_re = 0;
      acc_im = 0;
      for (int n = 0; n < radix; n++) begin
        case ((n * k) % 4)
          0: begin
            acc_re = acc_re + int'(a_re[n]);
            acc_im = acc_im + int'(a_im[n]);
          end
          1: begin
            acc_re = acc_re + int'(a_im[n]);
            acc_im = acc_im - int'(a_re[n]);
          end
          2: begin
            acc_re = acc_re - int'(a_re[n]);
            acc_im = acc_im - int'(a_im[n]);
          end
          default: begin
            acc_re = acc_re - int'(a_im[n]);
            acc_im = acc_im + int'(a_re[n]);
          end
        endcase
      end
      y_re[k] = sample_t'(acc_re >>> 2);
      y_im[k] = sample_t'(acc_im >>> 2);
    end
  endtask

  task automatic apply_twiddle(input sample_t a_re, input sample_t a_im, input int e,
                               output sample_t p_re, output sample_t p_im);
    longint wr;
    longint wi;
    longint pr;
    longint pi;
    wr = longint'(tw_re_table[e]);
    wi = longint'(tw_im_table[e]);
    pr = longint'(a_re) * wr - longint'(a_im) * wi;
    pi = longint'(a_re) * wi + longint'(a_im) * wr;
    p_re = sample_t'(pr >>> tw_frac);
    p_im = sample_t'(pi >>> tw_frac);
  endtask

  task automatic fft_model(input sample_t x_re [n_points], input sample_t x_im [n_points],
                           output sample_t y_re [n_points], output sample_t y_im [n_points]);
    sample_t g_re [n_points];
    sample_t g_im [n_points];
    sample_t c_re [radix];
    sample_t c_im [radix];
    sample_t d_re [radix];
    sample_t d_im [radix];
    // first pass takes stride-4 columns and applies twiddle j*k to each output
    for (int j = 0; j < n_butterflies; j++) begin
      for (int n = 0; n < radix; n++) begin
        c_re[n] = x_re[j + 4 * n];
        c_im[n] = x_im[j + 4 * n];
      end
      dft4(c_re, c_im, d_re, d_im);
      for (int k = 0; k < radix; k++) begin
        apply_twiddle(d_re[k], d_im[k], j * k, g_re[4 * j + k], g_im[4 * j + k]);
      end
    end
    // in the second pass output k2 of butterfly m is bin m + 4*k2
    for (int m = 0; m < n_butterflies; m++) begin
      for (int j = 0; j < radix; j++) begin
        c_re[j] = g_re[4 * j + m];
        c_im[j] = g_im[4 * j + m];
      end
      dft4(c_re, c_im, d_re, d_im);
      for (int k2 = 0; k2 < radix; k2++) begin
        y_re[m + 4 * k2] = d_re[k2];
        y_im[m + 4 * k2] = d_im[k2];
      end
    end
  endtask

  task automatic send_frame(input sample_t re [n_points], input sample_t im [n_points],
                            input sample_t er [n_points], input sample_t ei [n_points]);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    in_re = re;
    in_im = im;
    // accepted on the next edge and then through two registered stages
    due_q.push_back(cycle + 2);
    for (int b = 0; b < n_points; b++) begin
      exp_re_q.push_back(er[b]);
      exp_im_q.push_back(ei[b]);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic drain;
    idle_cycles(1);
    while (due_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  task automatic random_frame(output sample_t re [n_points], output sample_t im [n_points]);
    for (int b = 0; b < n_points; b++) begin
      re[b] = sample_t'($random(seed));
      im[b] = sample_t'($random(seed));
    end
  endtask

  // out_valid during reset is watched by the monitor
  task automatic quiet_after_reset;
    idle_cycles(6);
  endtask

  task automatic impulse_response;
    sample_t re [n_points];
    sample_t im [n_points];
    sample_t er [n_points];
    sample_t ei [n_points];
    for (int b = 0; b < n_points; b++) begin
      re[b] = '0;
      im[b] = '0;
      er[b] = 64;
      ei[b] = '0;
    end
    re[0] = 1024;
    send_frame(re, im, er, ei);
    drain();
  endtask

  task automatic dc_response;
    sample_t re [n_points];
    sample_t im [n_points];
    sample_t er [n_points];
    sample_t ei [n_points];
    for (int b = 0; b < n_points; b++) begin
      re[b] = 800;
      im[b] = '0;
      er[b] = '0;
      ei[b] = '0;
    end
    er[0] = 800;
    send_frame(re, im, er, ei);
    drain();
  endtask

  task automatic tone_response;
    sample_t re [n_points];
    sample_t im [n_points];
    sample_t er [n_points];
    sample_t ei [n_points];
    // cosine at three cycles per frame
    for (int n = 0; n < n_points; n++) begin
      re[n] = sample_t'(tw_re_table[(3 * n) % n_points] >>> 2);
      im[n] = '0;
    end
    fft_model(re, im, er, ei);
    send_frame(re, im, er, ei);
    drain();
  endtask

  task automatic back_to_back_stream;
    sample_t re [n_points];
    sample_t im [n_points];
    sample_t er [n_points];
    sample_t ei [n_points];
    repeat (n_random) begin
      random_frame(re, im);
      fft_model(re, im, er, ei);
      send_frame(re, im, er, ei);
    end
    drain();
  endtask

  task automatic gapped_stream;
    sample_t re [n_points];
    sample_t im [n_points];
    sample_t er [n_points];
    sample_t ei [n_points];
    int      gap;
    repeat (n_gapped) begin
      random_frame(re, im);
      fft_model(re, im, er, ei);
      send_frame(re, im, er, ei);
      gap = $unsigned($random(seed)) % (max_gap + 1);
      idle_cycles(gap);
    end
    drain();
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
  end

  initial begin : watchdog
    wait (cycle > timeout_cycles);
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    logic    due;
    sample_t er;
    sample_t ei;
    // the clock settles low at time zero before any rising edge
    if (cycle > 0) begin
      due = (due_q.size() > 0) && (due_q[0] == cycle);
      check_valid(due, out_valid);
      if (out_valid === 1'b1 && due_q.size() == 0) begin
        $display("out_valid went high at t=%0t while no frame was expected", $time);
        proto_errs++;
      end
      if (due) begin
        void'(due_q.pop_front());
        for (int b = 0; b < n_points; b++) begin
          er = exp_re_q.pop_front();
          ei = exp_im_q.pop_front();
          if (out_valid === 1'b1) begin
            check_sample("out_re", b, er, out_re[b]);
            check_sample("out_im", b, ei, out_im[b]);
          end
        end
      end
    end
  end

  initial begin
    seed = 32'hc22;
    rst = 1'b0;
    in_valid = 1'b0;
    for (int b = 0; b < n_points; b++) begin
      in_re[b] = '0;
      in_im[b] = '0;
    end
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst = 1'b1;

    quiet_after_reset();
    impulse_response();
    dc_response();
    tone_response();
    back_to_back_stream();
    gapped_stream();
    idle_cycles(2);

    assert_errs = dut0.u_assert.fail_count;
    $display("errors: %0d sample, %0d valid, %0d protocol, %0d assertion",
             sample_errs, valid_errs, proto_errs, assert_errs);
    if (sample_errs + valid_errs + proto_errs + assert_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
logic/fft_pkg.sv
logic/cmul.sv
logic/radix4_butterfly.sv
logic/fft_stage.sv
logic/fft16_top.sv
tb/tb_clock.sv
tb/fft16_assert.sv
tb/fft16_tb.sv
